//--- design/ooo_consts.svh
// Width, depth and latency macros for the dispatch and commit slice
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// Dispatch and retire width
`define WAYS 2

// Reorder buffer depth
`define ROB 8

// Physical register count
`define PRF 16

// Address width
`define XLEN 32

// Branch resolve latency in cycles
`define BR_LAT 3

`endif

//--- design/rob_types_pkg.sv
// Reorder buffer index, count, register number and address typedefs
`default_nettype none

`include "ooo_consts.svh"

package rob_types_pkg;

    // Slot in the reorder buffer
    typedef logic [$clog2(`ROB)-1:0] rob_idx_t;

    // Free count, one bit wider so a full count fits
    typedef logic [$clog2(`ROB):0] rob_cnt_t;

    // Physical register number
    typedef logic [$clog2(`PRF)-1:0] prn_t;

    // Architectural register number
    typedef logic [4:0] arn_t;

    // PC or target address
    typedef logic [`XLEN-1:0] addr_t;

endpackage

`default_nettype wire

//--- design/op_types_pkg.sv
// Opcode enum and instruction field typedefs
`default_nettype none

package op_types_pkg;

    // Opcode in bits 31..30 of the instruction word
    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,
        OP_ALU    = 2'd1,
        OP_BRANCH = 2'd2
    } op_e;

    // Raw instruction word
    typedef logic [31:0] instr_t;

    // Compare operand, bits 23..16 and 15..8
    typedef logic [7:0] imm_t;

    // Branch offset in words, bits 11..0
    typedef logic [11:0] offset_t;

endpackage

`default_nettype wire

//--- design/dispatch_decode.sv
// Instruction decode with reorder buffer index and physical register allocation
`timescale 1ns/100ps
`default_nettype none

`include "ooo_consts.svh"

module dispatch_decode (
    input  logic                                     clock,
    input  logic                                     rst_n,
    input  logic                                     flush,
    input  logic [`WAYS-1:0]                         in_valid,
    input  op_types_pkg::instr_t [`WAYS-1:0]         in_instr,
    input  rob_types_pkg::addr_t [`WAYS-1:0]         in_pc,
    input  logic [`WAYS-1:0]                         in_pred_taken,
    input  rob_types_pkg::addr_t [`WAYS-1:0]         in_pred_target,
    output logic [`WAYS-1:0]                         disp_valid,
    output op_types_pkg::op_e [`WAYS-1:0]            disp_op,
    output rob_types_pkg::rob_idx_t [`WAYS-1:0]      disp_idx,
    output rob_types_pkg::arn_t [`WAYS-1:0]          disp_arn,
    output rob_types_pkg::prn_t [`WAYS-1:0]          disp_prn,
    output rob_types_pkg::addr_t [`WAYS-1:0]         disp_pc,
    output logic [`WAYS-1:0]                         disp_pred_taken,
    output rob_types_pkg::addr_t [`WAYS-1:0]         disp_pred_target,
    output op_types_pkg::imm_t [`WAYS-1:0]           disp_a,
    output op_types_pkg::imm_t [`WAYS-1:0]           disp_b,
    output rob_types_pkg::addr_t [`WAYS-1:0]         disp_target
);

    import rob_types_pkg::*;
    import op_types_pkg::*;

    rob_idx_t             idx_ctr;
    prn_t                 prn_ctr;
    rob_cnt_t             n_valid;
    prn_t                 n_alu;
    op_e      [`WAYS-1:0] dec_op;
    rob_idx_t [`WAYS-1:0] dec_idx;
    prn_t     [`WAYS-1:0] dec_prn;
    addr_t    [`WAYS-1:0] dec_target;

    always_comb begin
        offset_t off;
        n_valid = '0;
        n_alu   = '0;
        for (int w = 0; w < `WAYS; w++) begin
            dec_op[w]     = op_e'(in_instr[w][31:30]);
            off           = in_instr[w][11:0];
            // Offset counts words and is zero extended
            dec_target[w] = in_pc[w] + (addr_t'(off) << 2);
            // Valid ways are packed, so way w takes the w-th slot
            dec_idx[w]    = idx_ctr + rob_idx_t'(w);
            dec_prn[w]    = '0;
            if (in_valid[w] && dec_op[w] == OP_ALU) begin
                dec_prn[w] = prn_ctr + n_alu;
                n_alu      = n_alu + prn_t'(1);
            end
            if (in_valid[w]) begin
                n_valid = n_valid + rob_cnt_t'(1);
            end
        end
    end

    // Counters and valid bits
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            disp_valid <= '0;
            idx_ctr    <= '0;
            prn_ctr    <= '0;
        end else if (flush) begin
            // Register numbers keep rotating across a flush
            disp_valid <= '0;
            idx_ctr    <= '0;
        end else begin
            disp_valid <= in_valid;
            idx_ctr    <= idx_ctr + rob_idx_t'(n_valid);
            prn_ctr    <= prn_ctr + n_alu;
        end
    end

    // Dispatch bundle payload
    always_ff @(posedge clock) begin
        for (int w = 0; w < `WAYS; w++) begin
            disp_op[w]          <= dec_op[w];
            disp_idx[w]         <= dec_idx[w];
            disp_arn[w]         <= in_instr[w][29:25];
            disp_prn[w]         <= dec_prn[w];
            disp_pc[w]          <= in_pc[w];
            disp_pred_taken[w]  <= in_pred_taken[w];
            disp_pred_target[w] <= in_pred_target[w];
            disp_a[w]           <= in_instr[w][23:16];
            disp_b[w]           <= in_instr[w][15:8];
            disp_target[w]      <= dec_target[w];
        end
    end

endmodule

`default_nettype wire

//--- design/branch_execute.sv
// ALU and branch execute lanes driving the common data bus
`timescale 1ns/100ps
`default_nettype none

`include "ooo_consts.svh"

module branch_execute (
    input  logic                                       clock,
    input  logic                                       rst_n,
    input  logic                                       flush,
    input  logic [`WAYS-1:0]                           disp_valid,
    input  op_types_pkg::op_e [`WAYS-1:0]              disp_op,
    input  rob_types_pkg::rob_idx_t [`WAYS-1:0]        disp_idx,
    input  op_types_pkg::imm_t [`WAYS-1:0]             disp_a,
    input  op_types_pkg::imm_t [`WAYS-1:0]             disp_b,
    input  rob_types_pkg::addr_t [`WAYS-1:0]           disp_target,
    output logic [2*`WAYS-1:0]                         cdb_valid,
    output rob_types_pkg::rob_idx_t [2*`WAYS-1:0]      cdb_idx,
    output logic [2*`WAYS-1:0]                         cdb_taken,
    output rob_types_pkg::addr_t [2*`WAYS-1:0]         cdb_target
);

    import rob_types_pkg::*;
    import op_types_pkg::*;

    logic [`WAYS-1:0] is_br;
    logic [`WAYS-1:0] is_alu;

    // One-stage ALU lane per way
    logic     [`WAYS-1:0] alu_valid;
    rob_idx_t [`WAYS-1:0] alu_idx;

    // Branch pipe per way, stage 0 is the youngest
    logic     [`WAYS-1:0][`BR_LAT-1:0] br_valid;
    rob_idx_t [`WAYS-1:0][`BR_LAT-1:0] br_idx;
    logic     [`WAYS-1:0][`BR_LAT-1:0] br_taken;
    addr_t    [`WAYS-1:0][`BR_LAT-1:0] br_target;

    always_comb begin
        for (int w = 0; w < `WAYS; w++) begin
            is_br[w]  = disp_valid[w] && disp_op[w] == OP_BRANCH;
            // NOPs complete through the ALU lane
            is_alu[w] = disp_valid[w] && disp_op[w] != OP_BRANCH;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            alu_valid <= '0;
            br_valid  <= '0;
        end else begin
            alu_valid <= is_alu;
            for (int w = 0; w < `WAYS; w++) begin
                br_valid[w][0] <= is_br[w];
                for (int s = 1; s < `BR_LAT; s++) begin
                    br_valid[w][s] <= br_valid[w][s-1];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int w = 0; w < `WAYS; w++) begin
            alu_idx[w]      <= disp_idx[w];
            br_idx[w][0]    <= disp_idx[w];
            // Taken on equal operands
            br_taken[w][0]  <= disp_a[w] == disp_b[w];
            br_target[w][0] <= disp_target[w];
            for (int s = 1; s < `BR_LAT; s++) begin
                br_idx[w][s]    <= br_idx[w][s-1];
                br_taken[w][s]  <= br_taken[w][s-1];
                br_target[w][s] <= br_target[w][s-1];
            end
        end
    end

    // Lanes 0..WAYS-1 carry ALU results, the upper lanes carry branches
    always_comb begin
        for (int w = 0; w < `WAYS; w++) begin
            cdb_valid[w]         = alu_valid[w];
            cdb_idx[w]           = alu_idx[w];
            cdb_taken[w]         = 1'b0;
            cdb_target[w]        = '0;
            cdb_valid[`WAYS+w]   = br_valid[w][`BR_LAT-1];
            cdb_idx[`WAYS+w]     = br_idx[w][`BR_LAT-1];
            cdb_taken[`WAYS+w]   = br_taken[w][`BR_LAT-1];
            cdb_target[`WAYS+w]  = br_target[w][`BR_LAT-1];
        end
    end

endmodule

`default_nettype wire

//--- design/reorder_buffer.sv
// Circular reorder buffer with completion, in-order retire and mispredict flush
`timescale 1ns/100ps
`default_nettype none

`include "ooo_consts.svh"

module reorder_buffer (
    input  logic                                       clock,
    input  logic                                       rst_n,
    input  logic [`WAYS-1:0]                           disp_valid,
    input  op_types_pkg::op_e [`WAYS-1:0]              disp_op,
    input  rob_types_pkg::arn_t [`WAYS-1:0]            disp_arn,
    input  rob_types_pkg::prn_t [`WAYS-1:0]            disp_prn,
    input  rob_types_pkg::addr_t [`WAYS-1:0]           disp_pc,
    input  logic [`WAYS-1:0]                           disp_pred_taken,
    input  rob_types_pkg::addr_t [`WAYS-1:0]           disp_pred_target,
    input  logic [2*`WAYS-1:0]                         cdb_valid,
    input  rob_types_pkg::rob_idx_t [2*`WAYS-1:0]      cdb_idx,
    input  logic [2*`WAYS-1:0]                         cdb_taken,
    input  rob_types_pkg::addr_t [2*`WAYS-1:0]         cdb_target,
    output rob_types_pkg::rob_cnt_t                    free_slots,
    output logic [`WAYS-1:0]                           commit_valid,
    output logic [`WAYS-1:0]                           commit_write,
    output rob_types_pkg::arn_t [`WAYS-1:0]            commit_arn,
    output rob_types_pkg::prn_t [`WAYS-1:0]            commit_prn,
    output rob_types_pkg::addr_t [`WAYS-1:0]           commit_pc,
    output logic                                       redirect_valid,
    output rob_types_pkg::addr_t                       redirect_pc,
    output logic                                       flush
);

    import rob_types_pkg::*;
    import op_types_pkg::*;

    // Entry array
    logic  [`ROB-1:0] e_done;
    logic  [`ROB-1:0] e_write;
    logic  [`ROB-1:0] e_branch;
    logic  [`ROB-1:0] e_pred_taken;
    logic  [`ROB-1:0] e_taken;
    logic  [`ROB-1:0] e_mispred;
    arn_t  [`ROB-1:0] e_arn;
    prn_t  [`ROB-1:0] e_prn;
    addr_t [`ROB-1:0] e_pc;
    addr_t [`ROB-1:0] e_pred_target;
    addr_t [`ROB-1:0] e_target;

    rob_idx_t head;
    rob_idx_t tail;
    rob_cnt_t used;
    rob_cnt_t n_disp;
    rob_cnt_t n_commit;

    always_comb begin
        n_disp = '0;
        for (int w = 0; w < `WAYS; w++) begin
            if (disp_valid[w]) begin
                n_disp = n_disp + rob_cnt_t'(1);
            end
        end
    end

    assign used = rob_cnt_t'(`ROB) - free_slots;

    // Retire walk from the head
    always_comb begin
        rob_idx_t slot;
        logic     stop;
        stop        = 1'b0;
        n_commit    = '0;
        flush       = 1'b0;
        redirect_pc = '0;
        for (int i = 0; i < `WAYS; i++) begin
            slot            = head + rob_idx_t'(i);
            commit_write[i] = e_write[slot];
            commit_arn[i]   = e_arn[slot];
            commit_prn[i]   = e_prn[slot];
            commit_pc[i]    = e_pc[slot];
            commit_valid[i] = 1'b0;
            // Only occupied slots count, freed ones may hold stale done bits
            if (!stop && rob_cnt_t'(i) < used && e_done[slot]) begin
                commit_valid[i] = 1'b1;
                n_commit        = n_commit + rob_cnt_t'(1);
                if (e_mispred[slot]) begin
                    flush       = 1'b1;
                    redirect_pc = e_taken[slot] ? e_target[slot] : e_pc[slot] + 4;
                    stop        = 1'b1;
                end
            end else begin
                stop = 1'b1;
            end
        end
    end

    assign redirect_valid = flush;

    // Pointers, free count and done bits
    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            head       <= '0;
            tail       <= '0;
            free_slots <= rob_cnt_t'(`ROB);
            e_done     <= '0;
        end else begin
            head       <= head + rob_idx_t'(n_commit);
            tail       <= tail + rob_idx_t'(n_disp);
            free_slots <= free_slots - n_disp + n_commit;
            for (int w = 0; w < `WAYS; w++) begin
                if (disp_valid[w]) begin
                    e_done[tail + rob_idx_t'(w)] <= 1'b0;
                end
            end
            for (int l = 0; l < 2*`WAYS; l++) begin
                if (cdb_valid[l]) begin
                    e_done[cdb_idx[l]] <= 1'b1;
                end
            end
        end
    end

    // Entry payload and branch outcome
    always_ff @(posedge clock) begin
        for (int w = 0; w < `WAYS; w++) begin
            if (disp_valid[w]) begin
                e_write[tail + rob_idx_t'(w)]       <= disp_op[w] == OP_ALU;
                e_branch[tail + rob_idx_t'(w)]      <= disp_op[w] == OP_BRANCH;
                e_arn[tail + rob_idx_t'(w)]         <= disp_arn[w];
                e_prn[tail + rob_idx_t'(w)]         <= disp_prn[w];
                e_pc[tail + rob_idx_t'(w)]          <= disp_pc[w];
                e_pred_taken[tail + rob_idx_t'(w)]  <= disp_pred_taken[w];
                e_pred_target[tail + rob_idx_t'(w)] <= disp_pred_target[w];
            end
        end
        for (int l = 0; l < 2*`WAYS; l++) begin
            if (cdb_valid[l]) begin
                e_taken[cdb_idx[l]]   <= cdb_taken[l];
                e_target[cdb_idx[l]]  <= cdb_target[l];
                // Wrong direction, or taken to the wrong place
                e_mispred[cdb_idx[l]] <= e_branch[cdb_idx[l]] &&
                    (cdb_taken[l] != e_pred_taken[cdb_idx[l]] ||
                     (cdb_taken[l] && cdb_target[l] != e_pred_target[cdb_idx[l]]));
            end
        end
    end

endmodule

`default_nettype wire

//--- design/ooo_core_top.sv
// Top level joining decode, execute and reorder buffer
`timescale 1ns/100ps
`default_nettype none

`include "ooo_consts.svh"

module ooo_core_top (
    input  logic                                   clock,
    input  logic                                   rst_n,
    input  logic [`WAYS-1:0]                       in_valid,
    input  op_types_pkg::instr_t [`WAYS-1:0]       in_instr,
    input  rob_types_pkg::addr_t [`WAYS-1:0]       in_pc,
    input  logic [`WAYS-1:0]                       in_pred_taken,
    input  rob_types_pkg::addr_t [`WAYS-1:0]       in_pred_target,
    output rob_types_pkg::rob_cnt_t                free_slots,
    output logic [`WAYS-1:0]                       commit_valid,
    output logic [`WAYS-1:0]                       commit_write,
    output rob_types_pkg::arn_t [`WAYS-1:0]        commit_arn,
    output rob_types_pkg::prn_t [`WAYS-1:0]        commit_prn,
    output rob_types_pkg::addr_t [`WAYS-1:0]       commit_pc,
    output logic                                   redirect_valid,
    output rob_types_pkg::addr_t                   redirect_pc
);

    import rob_types_pkg::*;
    import op_types_pkg::*;

    // Registered dispatch bundle
    logic     [`WAYS-1:0] disp_valid;
    op_e      [`WAYS-1:0] disp_op;
    rob_idx_t [`WAYS-1:0] disp_idx;
    arn_t     [`WAYS-1:0] disp_arn;
    prn_t     [`WAYS-1:0] disp_prn;
    addr_t    [`WAYS-1:0] disp_pc;
    logic     [`WAYS-1:0] disp_pred_taken;
    addr_t    [`WAYS-1:0] disp_pred_target;
    imm_t     [`WAYS-1:0] disp_a;
    imm_t     [`WAYS-1:0] disp_b;
    addr_t    [`WAYS-1:0] disp_target;

    // Common data bus, ALU lanes then branch lanes
    logic     [2*`WAYS-1:0] cdb_valid;
    rob_idx_t [2*`WAYS-1:0] cdb_idx;
    logic     [2*`WAYS-1:0] cdb_taken;
    addr_t    [2*`WAYS-1:0] cdb_target;

    logic flush;

    dispatch_decode u_decode (.*);

    branch_execute u_execute (.*);

    reorder_buffer u_rob (.*);

endmodule

`default_nettype wire

//--- dv/ooo_core_properties.sv
// Concurrent assertions on dispatch capacity, reset state and flush, bound to reorder_buffer
`timescale 1ns/100ps
`default_nettype none

`include "ooo_consts.svh"

module ooo_core_properties (
    input logic                    clock,
    input logic                    rst_n,
    input logic [`WAYS-1:0]        disp_valid,
    input rob_types_pkg::rob_cnt_t free_slots,
    input logic [`WAYS-1:0]        commit_valid,
    input logic                    redirect_valid,
    input logic                    flush
);

    import rob_types_pkg::*;

    // Source must respect the free count
    dispatch_fits: assert property (
        @(posedge clock) disable iff (!rst_n)
        $countones(disp_valid) <= int'(free_slots)
    ) else $error("dispatch exceeds free reorder buffer slots");

    // Buffer is empty right after reset
    quiet_after_reset: assert property (
        @(posedge clock)
        !rst_n |=> (commit_valid == '0 && !redirect_valid)
    ) else $error("commit or redirect in the cycle after reset");

    // Flush empties the buffer
    flush_empties: assert property (
        @(posedge clock) disable iff (!rst_n)
        flush |=> free_slots == rob_cnt_t'(`ROB)
    ) else $error("free slots not restored after flush");

endmodule

bind reorder_buffer ooo_core_properties u_props (.*);

`default_nettype wire

//--- dv/ooo_core_tb.sv
// Testbench for ooo_core_top with random stimulus, reference model, compare tasks and timeout
`timescale 1ns/100ps
`default_nettype none

`include "ooo_consts.svh"

module ooo_core_tb;

    import rob_types_pkg::*;
    import op_types_pkg::*;

    // Expected retirement record
    typedef struct packed {
        arn_t  arn;
        prn_t  prn;
        addr_t pc;
        logic  write;
        logic  mispred;
        addr_t redir;
    } expect_t;

    localparam int N_ALU   = 40;
    localparam int N_BR    = 40;
    localparam int N_MIX   = 120;
    localparam int LIMIT   = 4 * (N_ALU + N_BR + N_MIX) + 100;

    logic                 clock;
    logic                 rst_n;
    logic     [`WAYS-1:0] in_valid;
    instr_t   [`WAYS-1:0] in_instr;
    addr_t    [`WAYS-1:0] in_pc;
    logic     [`WAYS-1:0] in_pred_taken;
    addr_t    [`WAYS-1:0] in_pred_target;
    rob_cnt_t             free_slots;
    logic     [`WAYS-1:0] commit_valid;
    logic     [`WAYS-1:0] commit_write;
    arn_t     [`WAYS-1:0] commit_arn;
    prn_t     [`WAYS-1:0] commit_prn;
    addr_t    [`WAYS-1:0] commit_pc;
    logic                 redirect_valid;
    addr_t                redirect_pc;

    expect_t exp_q[$];
    string   test_name;
    int      seed;
    int      cycles;
    int      last_sent;
    addr_t   pc;
    prn_t    prn_next;

    ooo_core_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Branch rule applied to one instruction and its prediction
    function automatic void ref_branch(input addr_t bpc, input instr_t ins,
                                       input logic pt, input addr_t ptgt,
                                       output logic taken, output logic mispred,
                                       output addr_t redir);
        imm_t    a;
        imm_t    b;
        offset_t off;
        addr_t   tgt;
        a       = ins[23:16];
        b       = ins[15:8];
        off     = ins[11:0];
        tgt     = bpc + {18'd0, off, 2'b00};
        taken   = (a == b);
        mispred = (taken != pt) || (taken && tgt != ptgt);
        redir   = taken ? tgt : bpc + 32'd4;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_commit(input arn_t exp_arn, input arn_t act_arn,
                                input prn_t exp_prn, input prn_t act_prn,
                                input addr_t exp_pc, input addr_t act_pc,
                                input logic exp_write, input logic act_write);
        if (exp_pc != act_pc) begin
            stop_on_error($sformatf("ERROR %s commit pc: expected %h, actual %h", test_name,
                                    exp_pc, act_pc));
        end
        if (exp_arn != act_arn) begin
            stop_on_error($sformatf("ERROR %s commit arn: expected %h, actual %h", test_name,
                                    exp_arn, act_arn));
        end
        if (exp_prn != act_prn) begin
            stop_on_error($sformatf("ERROR %s commit prn: expected %h, actual %h", test_name,
                                    exp_prn, act_prn));
        end
        if (exp_write != act_write) begin
            stop_on_error($sformatf("ERROR %s commit write: expected %b, actual %b", test_name,
                                    exp_write, act_write));
        end
    endtask

    task automatic check_redirect(input addr_t exp_pc, input addr_t act_pc);
        if (exp_pc != act_pc) begin
            stop_on_error($sformatf("ERROR %s redirect pc: expected %h, actual %h", test_name,
                                    exp_pc, act_pc));
        end
    endtask

    task automatic check_count(input rob_cnt_t exp_cnt, input rob_cnt_t act_cnt);
        if (exp_cnt != act_cnt) begin
            stop_on_error($sformatf("ERROR %s free_slots: expected %0d, actual %0d", test_name,
                                    exp_cnt, act_cnt));
        end
    endtask

    // Build one instruction for a way and queue what it should retire as
    task automatic issue_one(input int w, input bit branches, input bit wrong);
        expect_t e;
        instr_t  ins;
        imm_t    a;
        imm_t    b;
        offset_t off;
        logic    taken;
        logic    pt;
        logic    mp;
        addr_t   redir;
        addr_t   ptgt;
        e.arn = arn_t'($unsigned($random(seed)) % 32);
        e.pc  = pc;
        if (branches && ($random(seed) & 1)) begin
            off = offset_t'($random(seed));
            b   = {4'($random(seed)), off[11:8]};
            a   = ($random(seed) & 1) ? b : imm_t'($random(seed));
            ins = {2'b10, e.arn, 1'b0, a, b, off[7:0]};
            ref_branch(pc, ins, 1'b0, pc, taken, mp, redir);
            // Mostly correct prediction
            pt   = taken;
            ptgt = taken ? redir : pc + 32'd4;
            if (wrong && ($unsigned($random(seed)) % 8) == 0) begin
                pt = ~pt;
            end
            if (wrong && taken && ($unsigned($random(seed)) % 8) == 0) begin
                ptgt = redir + 32'd4;
            end
            ref_branch(pc, ins, pt, ptgt, taken, mp, redir);
            e.prn     = '0;
            e.write   = 1'b0;
            e.mispred = mp;
            e.redir   = redir;
        end else begin
            ins       = {2'b01, e.arn, 1'b0, imm_t'($random(seed)), imm_t'($random(seed)), 8'h00};
            pt        = 1'b0;
            ptgt      = '0;
            e.prn     = prn_next;
            prn_next  = prn_next + prn_t'(1);
            e.write   = 1'b1;
            e.mispred = 1'b0;
            e.redir   = '0;
        end
        in_valid[w]       = 1'b1;
        in_instr[w]       = ins;
        in_pc[w]          = pc;
        in_pred_taken[w]  = pt;
        in_pred_target[w] = ptgt;
        pc = pc + 32'd4;
        exp_q.push_back(e);
    endtask

    task automatic run_phase(input string name, input int count, input bit branches,
                             input bit wrong);
        int sent;
        int avail;
        int n;
        test_name = name;
        sent      = 0;
        while (sent < count) begin
            @(negedge clock);
            in_valid = '0;
            if (redirect_valid) begin
                // Skip this cycle and restart fetch at the redirect
                pc        = redirect_pc;
                last_sent = 0;
            end else begin
                // Bundle from last cycle is not yet in free_slots
                avail = int'(free_slots) - last_sent;
                n     = int'($unsigned($random(seed)) % 3);
                if (n > avail) n = avail;
                if (n > count - sent) n = count - sent;
                for (int w = 0; w < n; w++) begin
                    issue_one(w, branches, wrong);
                end
                last_sent = n;
                sent      = sent + n;
            end
        end
        @(negedge clock);
        in_valid  = '0;
        last_sent = 0;
        while (exp_q.size() != 0) @(negedge clock);
        @(negedge clock);
        check_count(rob_cnt_t'(`ROB), free_slots);
    endtask

    // Compare commits and redirects against the queue
    always @(negedge clock) begin : compare
        expect_t e;
        logic    saw_redirect;
        saw_redirect = 1'b0;
        if (rst_n) begin
            for (int i = 0; i < `WAYS; i++) begin
                if (commit_valid[i]) begin
                    if (exp_q.size() == 0) begin
                        stop_on_error("commit seen with no instruction expected");
                    end
                    e = exp_q.pop_front();
                    check_commit(e.arn, commit_arn[i], e.prn, commit_prn[i], e.pc,
                                 commit_pc[i], e.write, commit_write[i]);
                    if (e.mispred) begin
                        if (!redirect_valid) begin
                            stop_on_error("mispredicted branch retired without a redirect");
                        end
                        check_redirect(e.redir, redirect_pc);
                        // Everything younger is flushed
                        exp_q.delete();
                        saw_redirect = 1'b1;
                    end
                end
            end
            if (redirect_valid && !saw_redirect) begin
                stop_on_error("redirect raised with no mispredicted branch retiring");
            end
        end
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: commits stopped");
            $display("Test FAILED");
            $fatal(1);
        end
    end

    initial begin
        seed           = 32'h183a_5472;
        cycles         = 0;
        last_sent      = 0;
        pc             = 32'h0000_1000;
        prn_next       = '0;
        test_name      = "reset";
        rst_n          = 1'b0;
        in_valid       = '0;
        in_instr       = '0;
        in_pc          = '0;
        in_pred_taken  = '0;
        in_pred_target = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        check_count(rob_cnt_t'(`ROB), free_slots);
        run_phase("alu_stream", N_ALU, 1'b0, 1'b0);
        run_phase("branch_correct", N_BR, 1'b1, 1'b0);
        run_phase("mispredict_mix", N_MIX, 1'b1, 1'b1);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/rob_types_pkg.sv
design/op_types_pkg.sv
design/dispatch_decode.sv
design/branch_execute.sv
design/reorder_buffer.sv
design/ooo_core_top.sv
dv/ooo_core_properties.sv
dv/ooo_core_tb.sv

//--- Makefile
# Verilator build and run for the dispatch and commit slice

VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
